// File: logic/soc_bus_pkg.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Bus widths and types of the system bus fabric
// Word address with the memory/IO flag on top, read as memory or IO view
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package soc_bus_pkg;

  localparam int DATA_W = 16;
  localparam int ADDR_W = 20;  // Word address plus IO flag
  localparam int SEL_W  = 2;
  localparam int PORT_W = 15;  // IO port word number

  typedef struct packed {
    logic              is_io;
    logic [ADDR_W-2:0] word;
  } mem_view_t;

  typedef struct packed {
    logic                     is_io;
    logic [ADDR_W-2-PORT_W:0] rsvd;  // Above the 64K IO space
    logic [PORT_W-1:0]        port;
  } io_view_t;

  typedef union packed {
    mem_view_t mem;
    io_view_t  io;
  } bus_addr_u;

  typedef enum logic [1:0] {IDLE, ACCESS, ACK} cycle_state_e;

endpackage

// File: logic/soc_map_pkg.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Memory and IO map of the fabric, slave indices and interrupt vectors
// Address and mask pairs are 20-bit words with the IO flag in bit 19
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package soc_map_pkg;

  typedef enum logic [1:0] {
    ROM  = 2'd0,
    GPIO = 2'd1,
    NONE = 2'd2   // Default slave
  } slave_e;

  // Boot ROM, memory 0xfff00 - 0xfffff
  localparam logic [soc_bus_pkg::ADDR_W-1:0] ROM_ADDR  = 20'h7ff80;
  localparam logic [soc_bus_pkg::ADDR_W-1:0] ROM_MASK  = 20'hfff80;

  // Switches and LEDs, IO 0xf100 - 0xf103
  localparam logic [soc_bus_pkg::ADDR_W-1:0] GPIO_ADDR = 20'h87880;
  localparam logic [soc_bus_pkg::ADDR_W-1:0] GPIO_MASK = 20'h87ffe;

  // Vectors returned on acknowledge cycles
  localparam logic [soc_bus_pkg::DATA_W-1:0] NMI_VECTOR      = 16'h0002;
  localparam logic [soc_bus_pkg::DATA_W-1:0] INT_VECTOR_BASE = 16'h0008;

  localparam int INT_W = 8;
  localparam int IID_W = 3;

endpackage

// File: logic/reset_debounce.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Reset debouncer, holds the internal reset after rst_lck is released
// Hold time is 2^DEBOUNCE_W - 1 cycles
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module reset_debounce #(
  parameter int DEBOUNCE_W = 17
) (
  input  logic clk,
  input  logic rst_lck,
  output logic sys_rst_n_o
);

  logic [DEBOUNCE_W-1:0] cnt;

  always_ff @(posedge clk) begin
    if (!rst_lck) begin
      cnt <= '1;              // Reload while the input is low
    end else if (cnt != '0) begin
      cnt <= cnt - 1'b1;
    end
  end

  // Out of reset once the count has run out
  assign sys_rst_n_o = (cnt == '0);

endmodule

// File: logic/bus_cycle_fsm.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Bus cycle FSM, IDLE to ACCESS to ACK for every request
// Strobes the decoded slave in ACCESS and owns the master acknowledge
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module bus_cycle_fsm (
  input  logic                clk,
  input  logic                sys_rst_n_i,
  input  logic                m_cyc_i,
  input  logic                m_stb_i,
  input  soc_map_pkg::slave_e slave_sel_i,
  output soc_map_pkg::slave_e cur_slave_o,
  output logic                rom_stb_o,
  output logic                gpio_stb_o,
  output logic                capture_o,
  output logic                m_ack_o
);

  import soc_bus_pkg::*;
  import soc_map_pkg::*;

  cycle_state_e state;

  always_ff @(posedge clk) begin
    if (!sys_rst_n_i) begin
      state       <= IDLE;
      cur_slave_o <= NONE;
    end else begin
      case (state)
        IDLE: begin
          if (m_cyc_i && m_stb_i) begin
            state       <= ACCESS;
            cur_slave_o <= slave_sel_i;  // Hold the decode for the cycle
          end
        end
        ACCESS:  state <= ACK;  // Slave write and read capture here
        ACK:     state <= IDLE;
        default: state <= IDLE;
      endcase
    end
  end

  assign capture_o = (state == ACCESS);

  // Single-cycle strobes, NONE gets none and is simply acknowledged
  assign rom_stb_o  = capture_o && (cur_slave_o == ROM);
  assign gpio_stb_o = capture_o && (cur_slave_o == GPIO);

  assign m_ack_o = (state == ACK);

endmodule

// File: logic/addr_decoder.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Address decoder, matches the bus address against the map
// ROM is matched in the memory view and GPIO in the IO view
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module addr_decoder (
  input  soc_bus_pkg::bus_addr_u adr_i,
  output soc_map_pkg::slave_e    slave_sel_o
);

  import soc_bus_pkg::*;
  import soc_map_pkg::*;

  logic rom_hit;
  logic gpio_hit;

  // The flag bit is always part of the match
  assign rom_hit = (adr_i.mem.is_io == ROM_ADDR[ADDR_W-1])
                && ((adr_i.mem.word & ROM_MASK[ADDR_W-2:0]) == ROM_ADDR[ADDR_W-2:0]);

  // Upper bits of the IO space are ignored, as on the real port decode
  assign gpio_hit = (adr_i.io.is_io == GPIO_ADDR[ADDR_W-1])
                 && ((adr_i.io.port & GPIO_MASK[PORT_W-1:0]) == GPIO_ADDR[PORT_W-1:0]);

  always_comb begin
    if (rom_hit) begin
      slave_sel_o = ROM;
    end else if (gpio_hit) begin
      slave_sel_o = GPIO;
    end else begin
      slave_sel_o = NONE;  // Unmapped
    end
  end

endmodule

// File: logic/boot_rom.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Boot ROM slave, a fixed table read combinationally
// Word i holds 0xB0 in the upper byte and i * 0x11 in the lower byte
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module boot_rom #(
  parameter int ROM_AW = 4
) (
  input  soc_bus_pkg::bus_addr_u         adr_i,
  output logic [soc_bus_pkg::DATA_W-1:0] dat_o
);

  import soc_bus_pkg::*;

  localparam int ROM_DEPTH = 2 ** ROM_AW;

  logic [DATA_W-1:0] rom_tbl [ROM_DEPTH];
  logic [ROM_AW-1:0] idx;

  // Table contents
  for (genvar i = 0; i < ROM_DEPTH; i++) begin : g_tbl
    assign rom_tbl[i] = {8'hb0, 8'(i * 'h11)};
  end

  // Low word address bits index the table, the region aliases above it
  assign idx = adr_i.mem.word[ROM_AW-1:0];

  // No write path
  assign dat_o = rom_tbl[idx];

endmodule

// File: logic/gpio_port.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Switch and LED port slave
// Port word 0 reads the switches, port word 1 is the LED register
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module gpio_port (
  input  logic                             clk,
  input  logic                             sys_rst_n_i,
  input  logic                             stb_i,
  input  logic                             we_i,
  input  logic                             port_word_i,
  input  logic [soc_bus_pkg::SEL_W-1:0]    sel_i,
  input  logic [soc_bus_pkg::DATA_W-1:0]   dat_i,
  input  logic [7:0]                       sw_i,
  output logic [soc_bus_pkg::DATA_W-1:0]   dat_o,
  output logic [soc_bus_pkg::DATA_W-1:0]   leds_o
);

  import soc_bus_pkg::*;

  logic [DATA_W-1:0] led_q;

  always_ff @(posedge clk) begin
    if (!sys_rst_n_i) begin
      led_q <= '0;
    end else if (stb_i && we_i && port_word_i) begin
      // Byte lanes follow the select bits
      for (int b = 0; b < SEL_W; b++) begin
        if (sel_i[b]) begin
          led_q[b*8 +: 8] <= dat_i[b*8 +: 8];
        end
      end
    end
  end

  // Switch port is read only
  assign dat_o  = port_word_i ? led_q : {8'h00, sw_i};
  assign leds_o = led_q;

endmodule

// File: logic/int_controller.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Priority interrupt controller with rising edge detection
// Lowest pending line wins, it is cleared at the end of its inta cycle
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module int_controller (
  input  logic                            clk,
  input  logic                            sys_rst_n_i,
  input  logic [soc_map_pkg::INT_W-1:0]   intv_i,
  input  logic                            inta_i,
  input  logic                            ack_i,
  output logic                            intr_o,
  output logic [soc_map_pkg::IID_W-1:0]   iid_o
);

  import soc_map_pkg::*;

  logic [INT_W-1:0] intv_q;
  logic [INT_W-1:0] pending;
  logic [INT_W-1:0] rise;
  logic [INT_W-1:0] clr;

  assign rise = intv_i & ~intv_q;

  // Scan from the top so the lowest set bit is left in iid_o
  always_comb begin
    iid_o = '0;
    for (int i = INT_W - 1; i >= 0; i--) begin
      if (pending[i]) iid_o = IID_W'(i);
    end
  end

  assign clr = (inta_i && ack_i) ? (INT_W'(1) << iid_o) : '0;

  always_ff @(posedge clk) begin
    if (!sys_rst_n_i) begin
      intv_q  <= '0;
      pending <= '0;
    end else begin
      intv_q  <= intv_i;
      pending <= (pending & ~clr) | rise;  // A new edge beats the clear
    end
  end

  assign intr_o = |pending;

endmodule

// File: logic/read_data_mux.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Read data register of the master port
// Captures an acknowledge vector or the selected slave's word
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module read_data_mux (
  input  logic                             clk,
  input  logic                             capture_i,
  input  soc_map_pkg::slave_e              cur_slave_i,
  input  logic [soc_bus_pkg::DATA_W-1:0]   rom_dat_i,
  input  logic [soc_bus_pkg::DATA_W-1:0]   gpio_dat_i,
  input  logic                             inta_i,
  input  logic                             nmia_i,
  input  logic [soc_map_pkg::IID_W-1:0]    iid_i,
  output logic [soc_bus_pkg::DATA_W-1:0]   m_dat_o
);

  import soc_bus_pkg::*;
  import soc_map_pkg::*;

  always_ff @(posedge clk) begin
    if (capture_i) begin
      if (nmia_i) begin
        m_dat_o <= NMI_VECTOR;                          // Fixed NMI vector
      end else if (inta_i) begin
        m_dat_o <= INT_VECTOR_BASE + DATA_W'(iid_i);
      end else begin
        case (cur_slave_i)
          ROM:     m_dat_o <= rom_dat_i;
          GPIO:    m_dat_o <= gpio_dat_i;
          default: m_dat_o <= '0;                       // Default slave
        endcase
      end
    end
  end

endmodule

// File: logic/soc_bus_top.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Bus fabric top level, the CPU side is the master port
// Decodes each cycle to boot ROM, GPIO or the default slave and returns
// interrupt vectors on acknowledge cycles
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module soc_bus_top #(
  parameter int DEBOUNCE_W = 17,
  parameter int ROM_AW     = 4
) (
  input  logic                                clk,
  input  logic                                rst_lck,
  input  soc_bus_pkg::bus_addr_u              m_adr_i,
  input  logic                                m_tga_i,
  input  logic [soc_bus_pkg::DATA_W-1:0]      m_dat_i,
  input  logic [soc_bus_pkg::SEL_W-1:0]       m_sel_i,
  input  logic                                m_we_i,
  input  logic                                m_cyc_i,
  input  logic                                m_stb_i,
  input  logic                                inta_i,
  input  logic                                nmia_i,
  input  logic [7:0]                          sw_i,
  input  logic [soc_map_pkg::INT_W-1:0]       intv_i,
  output logic [soc_bus_pkg::DATA_W-1:0]      m_dat_o,
  output logic                                m_ack_o,
  output logic [soc_bus_pkg::DATA_W-1:0]      leds_o,
  output logic                                intr_o
);

  import soc_bus_pkg::*;
  import soc_map_pkg::*;

  logic              sys_rst_n;
  bus_addr_u         dec_adr;
  slave_e            slave_sel;
  slave_e            cur_slave;
  logic              gpio_stb;
  logic              capture;
  logic [DATA_W-1:0] rom_dat;
  logic [DATA_W-1:0] gpio_dat;
  logic [IID_W-1:0]  iid;

  // IO flag travels on tga, fold it into the address
  assign dec_adr = {m_tga_i, m_adr_i.mem.word};

  reset_debounce #(.DEBOUNCE_W(DEBOUNCE_W)) i_reset_debounce (
    .clk         (clk),
    .rst_lck     (rst_lck),
    .sys_rst_n_o (sys_rst_n)
  );

  bus_cycle_fsm i_bus_cycle_fsm (
    .clk         (clk),
    .sys_rst_n_i (sys_rst_n),
    .m_cyc_i     (m_cyc_i),
    .m_stb_i     (m_stb_i),
    .slave_sel_i (slave_sel),
    .cur_slave_o (cur_slave),
    .rom_stb_o   (),          // ROM reads are combinational
    .gpio_stb_o  (gpio_stb),
    .capture_o   (capture),
    .m_ack_o     (m_ack_o)
  );

  addr_decoder i_addr_decoder (
    .adr_i       (dec_adr),
    .slave_sel_o (slave_sel)
  );

  boot_rom #(.ROM_AW(ROM_AW)) i_boot_rom (
    .adr_i (dec_adr),
    .dat_o (rom_dat)
  );

  gpio_port i_gpio_port (
    .clk         (clk),
    .sys_rst_n_i (sys_rst_n),
    .stb_i       (gpio_stb),
    .we_i        (m_we_i),
    .port_word_i (dec_adr.io.port[0]),
    .sel_i       (m_sel_i),
    .dat_i       (m_dat_i),
    .sw_i        (sw_i),
    .dat_o       (gpio_dat),
    .leds_o      (leds_o)
  );

  int_controller i_int_controller (
    .clk         (clk),
    .sys_rst_n_i (sys_rst_n),
    .intv_i      (intv_i),
    .inta_i      (inta_i),
    .ack_i       (m_ack_o),
    .intr_o      (intr_o),
    .iid_o       (iid)
  );

  read_data_mux i_read_data_mux (
    .clk         (clk),
    .capture_i   (capture),
    .cur_slave_i (cur_slave),
    .rom_dat_i   (rom_dat),
    .gpio_dat_i  (gpio_dat),
    .inta_i      (inta_i),
    .nmia_i      (nmia_i),
    .iid_i       (iid),
    .m_dat_o     (m_dat_o)
  );

endmodule

// File: testbench/tb_bus_tasks.svh
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Bus cycle tasks and reference model of the memory and IO map
// Included inside the testbench module and drives its signals directly
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`ifndef TB_BUS_TASKS_SVH
`define TB_BUS_TASKS_SVH

// ROM table word for an index
function automatic logic [15:0] rom_word(input logic [3:0] idx);
  return {8'hb0, idx * 8'h11};
endfunction

// Expected read data for a byte address, IO or memory
function automatic logic [15:0] map_read(input logic io, input logic [19:0] adr);
  if (!io && adr[19:8] == 12'hfff) begin
    return rom_word(adr[4:1]);  // 16 words repeat over the region
  end else if (io && adr[19:2] == 18'h03c40) begin
    return adr[1] ? led_model : {8'h00, sw_model};
  end
  return 16'h0000;
endfunction

// LED register follows byte selects, everything else ignores writes
task automatic model_write(input logic io, input logic [19:0] adr,
                           input logic [1:0] sel, input logic [15:0] dat);
  if (io && adr[19:2] == 18'h03c40 && adr[1]) begin
    if (sel[0]) led_model[7:0] = dat[7:0];
    if (sel[1]) led_model[15:8] = dat[15:8];
  end
endtask

function automatic int lowest_line(input logic [7:0] pend);
  for (int i = 0; i < 8; i++) begin
    if (pend[i]) return i;
  end
  return 0;
endfunction

// One master cycle, held until the acknowledge is seen
task automatic run_cycle(input logic io, input logic [19:0] adr, input logic we,
                         input logic [1:0] sel, input logic [15:0] dat,
                         input logic inta, input logic nmia, input logic [15:0] exp);
  int waited;
  waited = 0;
  @(posedge clk);
  exp_dat = exp;
  chk_dat = !we;                   // Only reads carry data back
  m_adr_i.mem.is_io <= io;
  m_adr_i.mem.word  <= adr[19:1];
  m_tga_i <= io;
  m_we_i  <= we;
  m_sel_i <= sel;
  m_dat_i <= dat;
  inta_i  <= inta;
  nmia_i  <= nmia;
  m_cyc_i <= 1'b1;
  m_stb_i <= 1'b1;
  do begin
    @(negedge clk);                // Ack looked at mid cycle
    waited++;
  end while (!m_ack_o && waited < ACK_WAIT);
  if (!m_ack_o) begin
    $display("No acknowledge within %0d cycles in test %s", ACK_WAIT, test_name);
    lost_cnt++;
  end
  @(posedge clk);
  m_cyc_i <= 1'b0;
  m_stb_i <= 1'b0;
  m_we_i  <= 1'b0;
  inta_i  <= 1'b0;
  nmia_i  <= 1'b0;
endtask

task automatic bus_read(input logic io, input logic [19:0] adr, input logic [15:0] exp);
  run_cycle(io, adr, 1'b0, 2'b11, 16'h0000, 1'b0, 1'b0, exp);
endtask

task automatic bus_write(input logic io, input logic [19:0] adr,
                         input logic [1:0] sel, input logic [15:0] dat);
  run_cycle(io, adr, 1'b1, sel, dat, 1'b0, 1'b0, 16'h0000);
  model_write(io, adr, sel, dat);
endtask

// Interrupt acknowledge, vector is base 8 plus the lowest pending line
task automatic int_ack_cycle();
  int id;
  id = lowest_line(int_model);
  run_cycle(1'b0, 20'h00000, 1'b0, 2'b11, 16'h0000, 1'b1, 1'b0, 16'h0008 + 16'(id));
  int_model[id] = 1'b0;
  exp_intr = |int_model;
endtask

`endif

// File: testbench/tb_soc_bus.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench of the bus fabric, plays the CPU on the master port
// Runs reset, ROM, GPIO, default slave and interrupt tests under assertions
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module tb_soc_bus;

  import soc_bus_pkg::*;

  localparam int SEED        = 32'h453c;
  localparam int RST_CYCLES  = 4;
  localparam int RST_WIN     = 26;    // rst_lck low plus 15 hold cycles and margin
  localparam int ACK_WAIT    = 8;
  localparam int CYCLE_LIMIT = 2000;  // Generous bound on the whole run

  logic              clk;
  logic              rst_lck;
  bus_addr_u         m_adr_i;
  logic              m_tga_i;
  logic [DATA_W-1:0] m_dat_i;
  logic [SEL_W-1:0]  m_sel_i;
  logic              m_we_i;
  logic              m_cyc_i;
  logic              m_stb_i;
  logic              inta_i;
  logic              nmia_i;
  logic [7:0]        sw_i;
  logic [7:0]        intv_i;
  logic [DATA_W-1:0] m_dat_o;
  logic              m_ack_o;
  logic [DATA_W-1:0] leds_o;
  logic              intr_o;

  int                cyc_cnt = 0;
  int                err_cnt = 0;
  int                lost_cnt;
  int                marks_at_start;
  int                tests_passed;
  int                tests_failed;
  logic              live;            // Past the reset window
  logic              chk_dat;
  logic              exp_intr;
  logic [DATA_W-1:0] exp_dat;
  logic [DATA_W-1:0] led_model;
  logic [7:0]        sw_model;
  logic [7:0]        int_model;
  string             test_name;

  `include "tb_bus_tasks.svh"

  soc_bus_top #(.DEBOUNCE_W(4)) i_soc_bus_top (
    .clk     (clk),
    .rst_lck (rst_lck),
    .m_adr_i (m_adr_i),
    .m_tga_i (m_tga_i),
    .m_dat_i (m_dat_i),
    .m_sel_i (m_sel_i),
    .m_we_i  (m_we_i),
    .m_cyc_i (m_cyc_i),
    .m_stb_i (m_stb_i),
    .inta_i  (inta_i),
    .nmia_i  (nmia_i),
    .sw_i    (sw_i),
    .intv_i  (intv_i),
    .m_dat_o (m_dat_o),
    .m_ack_o (m_ack_o),
    .leds_o  (leds_o),
    .intr_o  (intr_o)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  always @(posedge clk) begin
    cyc_cnt <= cyc_cnt + 1;
    if (cyc_cnt == CYCLE_LIMIT) begin
      $display("Timeout after %0d cycles, the tests did not complete", CYCLE_LIMIT);
      $display("Simulation failed");
      $finish;
    end
  end

  a_read_data: assert property (@(posedge clk) (m_ack_o && chk_dat) |-> (m_dat_o == exp_dat))
    else begin
      $display("FAILED %s expected %h actual %h", test_name, exp_dat, m_dat_o);
      err_cnt++;
    end

  // Ack two edges after the request is first sampled, for one cycle only
  a_ack_late: assert property (@(posedge clk)
      m_ack_o |-> ($past(m_stb_i, 2) && !$past(m_stb_i, 3)))
    else begin
      $display("Acknowledge in test %s came at the wrong edge", test_name);
      err_cnt++;
    end

  a_ack_due: assert property (@(posedge clk)
      (live && $past(m_stb_i, 2) && !$past(m_stb_i, 3)) |-> m_ack_o)
    else begin
      $display("Request in test %s was not acknowledged two edges later", test_name);
      err_cnt++;
    end

  a_ack_single: assert property (@(posedge clk) !(m_ack_o && $past(m_ack_o)))
    else begin
      $display("Acknowledge in test %s stayed high for more than one cycle", test_name);
      err_cnt++;
    end

  a_reset_quiet: assert property (@(posedge clk)
      (cyc_cnt >= 2 && !live) |-> (!m_ack_o && !intr_o && leds_o == '0))
    else begin
      $display("Outputs were not quiet inside the reset window in test %s", test_name);
      err_cnt++;
    end

  a_leds: assert property (@(posedge clk) (live && !m_cyc_i) |-> (leds_o == led_model))
    else begin
      $display("FAILED %s expected %h actual %h", test_name, led_model, leds_o);
      err_cnt++;
    end

  a_intr: assert property (@(posedge clk) (live && !m_cyc_i) |-> (intr_o == exp_intr))
    else begin
      $display("FAILED %s expected %b actual %b", test_name, exp_intr, intr_o);
      err_cnt++;
    end

  task automatic start_test(input string name);
    test_name = name;
    marks_at_start = err_cnt + lost_cnt;
  endtask

  // Lets the checks on the last edges of the test land first
  task automatic finish_test();
    @(posedge clk);
    @(negedge clk);
    if (err_cnt + lost_cnt == marks_at_start) begin
      tests_passed++;
      $display("PASS  %s", test_name);
    end else begin
      tests_failed++;
      $display("FAIL  %s", test_name);
    end
  endtask

  initial begin
    logic [19:0] adr;
    logic [15:0] dat;
    void'($urandom(SEED));
    rst_lck = 1'b0;
    m_adr_i = '0;
    m_tga_i = 1'b0;
    m_dat_i = '0;
    m_sel_i = '0;
    m_we_i  = 1'b0;
    m_cyc_i = 1'b0;
    m_stb_i = 1'b0;
    inta_i  = 1'b0;
    nmia_i  = 1'b0;
    sw_i    = '0;
    intv_i  = '0;
    live = 1'b0;
    chk_dat = 1'b0;
    exp_intr = 1'b0;
    exp_dat = '0;
    led_model = '0;
    sw_model = '0;
    int_model = '0;
    lost_cnt = 0;
    tests_passed = 0;
    tests_failed = 0;

    start_test("reset");
    repeat (RST_CYCLES) @(posedge clk);
    rst_lck <= 1'b1;
    repeat (3) @(posedge clk);
    m_adr_i.mem.word <= 19'h7ff80;  // Request and interrupt edge inside the hold
    m_cyc_i <= 1'b1;
    m_stb_i <= 1'b1;
    intv_i  <= 8'h01;
    repeat (8) @(posedge clk);
    m_cyc_i <= 1'b0;
    m_stb_i <= 1'b0;
    intv_i  <= 8'h00;
    while (cyc_cnt < RST_WIN) @(posedge clk);
    live = 1'b1;
    finish_test();

    start_test("handshake");
    for (int n = 0; n < 4; n++) begin
      adr = 20'($urandom) & 20'hffffe;
      bus_read(1'b0, adr, map_read(1'b0, adr));
    end
    finish_test();

    start_test("rom_read");
    for (int n = 0; n < 8; n++) begin
      adr = {12'hfff, 8'($urandom) & 8'hfe};
      bus_read(1'b0, adr, map_read(1'b0, adr));
    end
    finish_test();

    start_test("rom_write");
    bus_write(1'b0, 20'hfff06, 2'b11, 16'h1234);
    bus_read(1'b0, 20'hfff06, map_read(1'b0, 20'hfff06));
    finish_test();

    start_test("gpio_switch");
    for (int n = 0; n < 2; n++) begin
      sw_model = 8'($urandom);
      @(posedge clk);
      sw_i <= sw_model;
      bus_read(1'b1, 20'h0f100, map_read(1'b1, 20'h0f100));
    end
    finish_test();

    start_test("gpio_leds");
    for (int s = 0; s < 4; s++) begin
      dat = 16'($urandom);
      bus_write(1'b1, 20'h0f102, 2'(s), dat);
      bus_read(1'b1, 20'h0f102, map_read(1'b1, 20'h0f102));
    end
    finish_test();

    start_test("default_slave");
    bus_read(1'b0, 20'h00000, map_read(1'b0, 20'h00000));
    bus_read(1'b0, 20'hffefe, map_read(1'b0, 20'hffefe));
    bus_read(1'b0, 20'h0f100, map_read(1'b0, 20'h0f100));  // GPIO port but memory space
    bus_read(1'b1, 20'h0f0fe, map_read(1'b1, 20'h0f0fe));
    bus_read(1'b1, 20'h0f104, map_read(1'b1, 20'h0f104));
    bus_read(1'b1, 20'h0ff00, map_read(1'b1, 20'h0ff00));
    finish_test();

    start_test("interrupts");
    @(posedge clk);
    intv_i <= 8'h24;                 // Lines 5 and 2
    @(posedge clk);
    int_model = 8'h24;
    exp_intr = 1'b1;
    int_ack_cycle();
    int_ack_cycle();
    @(posedge clk);
    intv_i <= 8'h00;
    finish_test();

    start_test("nmi");
    run_cycle(1'b0, 20'h00000, 1'b0, 2'b11, 16'h0000, 1'b0, 1'b1, 16'h0002);
    finish_test();

    $display("Tests passed %0d, tests failed %0d, failing checks %0d",
             tests_passed, tests_failed, err_cnt + lost_cnt);
    if (err_cnt == 0 && lost_cnt == 0 && tests_failed == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// File: files.f
+incdir+testbench
logic/soc_bus_pkg.sv
logic/soc_map_pkg.sv
logic/reset_debounce.sv
logic/bus_cycle_fsm.sv
logic/addr_decoder.sv
logic/boot_rom.sv
logic/gpio_port.sv
logic/int_controller.sv
logic/read_data_mux.sv
logic/soc_bus_top.sv
testbench/tb_soc_bus.sv

// File: run_sim.sh
#!/bin/sh
# Builds the bus fabric testbench with Verilator and runs it.
# The exit status is nonzero when the log reports a failure.
set -e

cd "$(dirname "$0")"

verilator --binary --assert -j 0 --top-module tb_soc_bus -f files.f -o tb_soc_bus

./obj_dir/tb_soc_bus > sim.log 2>&1
cat sim.log

if grep -q "Simulation failed" sim.log; then
  exit 1
fi
exit 0
